//--- common/uart_cfg_pkg.sv
// UART link configuration
// Frame geometry, parity mode and transmit control states.
// One baud_clk edge equals one bit period on the line.

package uart_cfg_pkg;

    localparam int data_bits      = 8;              // Payload bits per frame
    localparam int frame_bits     = data_bits + 3;  // Start, data, parity, stop
    localparam int last_bit_index = frame_bits - 1; // Stop bit position

    // Parity mode: 0 selects even, 1 would select odd
    localparam logic parity_odd = 1'b0;

    // Transmit control states
    typedef enum logic {
        tx_idle = 1'b0,  // Line high, waiting for start strobe
        tx_send = 1'b1   // Frame bits going out
    } tx_state_e;

endpackage : uart_cfg_pkg

//--- common/uart_frame_pkg.sv
// UART frame types
// The 11-bit frame word seen as raw line bits or as named fields,
// plus the result record the receiver hands out.

package uart_frame_pkg;

    import uart_cfg_pkg::*;

    // Field view, high to low, so start lands in bit 0
    typedef struct packed {
        logic                 stop;    // Must be 1
        logic                 parity;  // Parity over data
        logic [data_bits-1:0] data;    // LSB goes out first
        logic                 start;   // Must be 0
    } uart_fields_t;

    // One frame word, two ways to read it
    typedef union packed {
        logic [frame_bits-1:0] raw;     // Bit 0 is on the line first
        uart_fields_t          fields;  // Decoded layout
    } uart_frame_u;

    // Receiver output record, 10 bits
    typedef struct packed {
        logic [data_bits-1:0] data;         // Received byte
        logic                 parity_err;   // Parity bit mismatch
        logic                 framing_err;  // Stop bit was low
    } rx_result_t;

endpackage : uart_frame_pkg

//--- uart_tx/tx_ctrl_fsm.sv
// Transmit control FSM
// Waits in idle for a start strobe, pulses load to the shifter and counter,
// then holds shift_en and tx_busy for the whole frame.
// A strobe on the stop-bit edge starts the next frame with no gap.

module tx_ctrl_fsm
    import uart_cfg_pkg::*;
(
    input  logic baud_clk,
    input  logic rst_n,     // Sync, active low
    input  logic start_tx,  // Single-cycle request
    input  logic last_bit,  // Stop bit is on the line
    output logic load,      // Frame load and counter clear
    output logic shift_en,  // Advance shifter and counter
    output logic tx_busy    // High while frame is sent
);

    tx_state_e state_q;
    tx_state_e state_d;

    // Strobe is taken in idle or on the final bit of a frame
    always_comb begin
        load    = 1'b0;
        state_d = state_q;
        case (state_q)
            tx_idle: begin
                if (start_tx) begin
                    load    = 1'b1;     // Capture byte this edge
                    state_d = tx_send;
                end
            end
            tx_send: begin
                if (last_bit) begin
                    if (start_tx) begin
                        load    = 1'b1; // Back-to-back frame
                        state_d = tx_send;
                    end else begin
                        state_d = tx_idle;
                    end
                end
            end
            default: state_d = tx_idle;
        endcase
    end

    always_ff @(posedge baud_clk) begin
        if (!rst_n) begin
            state_q <= tx_idle;
        end else begin
            state_q <= state_d;
        end
    end

    assign shift_en = (state_q == tx_send);  // Level over all 11 bits
    assign tx_busy  = (state_q == tx_send);  // Same window, seen outside

endmodule : tx_ctrl_fsm

//--- uart_tx/tx_bit_counter.sv
// Transmit bit counter
// Tracks which frame bit is on the line and flags the stop bit
// so the control FSM knows when the frame ends.

module tx_bit_counter
    import uart_cfg_pkg::*;
(
    input  logic baud_clk,
    input  logic rst_n,     // Sync, active low
    input  logic clear,     // Restart at bit 0
    input  logic count_en,  // One step per bit
    output logic last_bit   // Count sits on stop bit
);

    localparam int cnt_w = $clog2(frame_bits);  // 4 bits for 11 positions

    logic [cnt_w-1:0] count_q;

    always_ff @(posedge baud_clk) begin
        if (!rst_n) begin
            count_q <= '0;
        end else if (clear) begin
            count_q <= '0;            // Clear wins over count
        end else if (count_en) begin
            count_q <= count_q + 1'b1;
        end
    end

    assign last_bit = (count_q == cnt_w'(last_bit_index));

endmodule : tx_bit_counter

//--- uart_tx/tx_frame_shifter.sv
// Transmit frame shifter
// Builds start, data, even parity and stop into one frame word on load,
// then shifts it out LSB first. Shifting fills with ones, so the line
// rests high once the frame is gone.

module tx_frame_shifter
    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;
(
    input  logic                 baud_clk,
    input  logic                 rst_n,     // Sync, active low
    input  logic                 load,      // Capture new frame
    input  logic                 shift_en,  // Move to next bit
    input  logic [data_bits-1:0] data,      // Byte to send
    output logic                 tx         // Serial line
);

    uart_frame_u frame_q;
    uart_frame_u frame_new;
    logic        parity_bit;

    // XOR reduction gives even parity, mode bit flips it for odd
    assign parity_bit = (^data) ^ parity_odd;

    always_comb begin
        frame_new.fields.stop   = 1'b1;
        frame_new.fields.parity = parity_bit;
        frame_new.fields.data   = data;
        frame_new.fields.start  = 1'b0;
    end

    always_ff @(posedge baud_clk) begin
        if (!rst_n) begin
            frame_q.raw <= '1;  // Idle line level
        end else if (load) begin
            frame_q <= frame_new;  // Load beats shift on back-to-back
        end else if (shift_en) begin
            frame_q.raw <= {1'b1, frame_q.raw[frame_bits-1:1]};
        end
    end

    assign tx = frame_q.raw[0];  // Current bit

endmodule : tx_frame_shifter

//--- uart_rx/rx_frame_sampler.sv
// Receive frame sampler
// Line is synchronous to baud_clk, so one sample per edge is enough.
// A low sample in idle starts a frame, ten more edges collect the rest.
// After the stop bit the frame is decoded and valid pulses for one cycle
// with the byte and the parity and framing checks.

module rx_frame_sampler
    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;
(
    input  logic       baud_clk,
    input  logic       rst_n,      // Sync, active low
    input  logic       rx,         // Serial line in
    output logic       rx_valid,   // One-cycle result strobe
    output rx_result_t rx_result   // Byte and error flags
);

    localparam int cnt_w = $clog2(frame_bits);

    logic             receiving_q;  // 0 idle, 1 collecting bits
    logic [cnt_w-1:0] count_q;      // Bits already taken
    uart_frame_u      frame_q;      // Fills from the top
    logic             parity_exp;

    // Control state
    always_ff @(posedge baud_clk) begin
        if (!rst_n) begin
            receiving_q <= 1'b0;
            count_q     <= '0;
            rx_valid    <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (!receiving_q) begin
                if (!rx) begin
                    receiving_q <= 1'b1;  // Start bit seen
                    count_q     <= cnt_w'(1);
                end
            end else if (count_q == cnt_w'(last_bit_index)) begin
                receiving_q <= 1'b0;      // Stop bit taken this edge
                count_q     <= '0;
                rx_valid    <= 1'b1;
            end else begin
                count_q <= count_q + 1'b1;
            end
        end
    end

    // Shift register, takes every bit from start through stop
    always_ff @(posedge baud_clk) begin
        if (receiving_q || !rx) begin
            frame_q.raw <= {rx, frame_q.raw[frame_bits-1:1]};
        end
    end

    // Frame holds still while idle, so decode straight from it
    assign parity_exp = (^frame_q.fields.data) ^ parity_odd;

    always_comb begin
        rx_result.data        = frame_q.fields.data;
        rx_result.parity_err  = (frame_q.fields.parity != parity_exp);
        rx_result.framing_err = ~frame_q.fields.stop;  // Stop must be high
    end

endmodule : rx_frame_sampler

//--- design/uart_link_top.sv
// UART link top
// Transmit path (control FSM, bit counter, frame shifter) and the
// receive sampler side by side, all on the bit-rate clock.
// Only wiring and instances live here.

module uart_link_top
    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;
(
    input  logic                 baud_clk,  // One edge per bit
    input  logic                 rst_n,     // Sync, active low
    input  logic [data_bits-1:0] tx_data,   // Byte to transmit
    input  logic                 start_tx,  // Start strobe
    output logic                 tx,        // Serial out
    output logic                 tx_busy,   // Frame in progress
    input  logic                 rx,        // Serial in
    output logic                 rx_valid,  // Result strobe
    output rx_result_t           rx_result  // Byte and errors
);

    logic load;      // Frame capture and count clear
    logic shift_en;  // Bit advance
    logic last_bit;  // Stop bit on the line

    tx_ctrl_fsm u_tx_ctrl (
        .baud_clk (baud_clk),
        .rst_n    (rst_n),
        .start_tx (start_tx),
        .last_bit (last_bit),
        .load     (load),
        .shift_en (shift_en),
        .tx_busy  (tx_busy)
    );

    tx_bit_counter u_tx_count (
        .baud_clk (baud_clk),
        .rst_n    (rst_n),
        .clear    (load),
        .count_en (shift_en),
        .last_bit (last_bit)
    );

    tx_frame_shifter u_tx_shift (
        .baud_clk (baud_clk),
        .rst_n    (rst_n),
        .load     (load),
        .shift_en (shift_en),
        .data     (tx_data),
        .tx       (tx)
    );

    rx_frame_sampler u_rx (
        .baud_clk  (baud_clk),
        .rst_n     (rst_n),
        .rx        (rx),
        .rx_valid  (rx_valid),
        .rx_result (rx_result)
    );

endmodule : uart_link_top

//--- bench/uart_link_tb.sv
// UART link testbench
// Runs the test lines of the stimulus file against the DUT. Loopback bytes
// are checked bit by bit on tx and again as results on rx, raw frames go
// straight onto rx, and busy lines throw a second strobe into a frame.
// A monitor matches every rx_valid against the frames in flight.

module uart_link_tb
    import uart_cfg_pkg::*;
    import uart_frame_pkg::*;
();

    localparam int max_tests = 64;
    localparam int mode_loop = 0;
    localparam int mode_raw  = 1;
    localparam int mode_busy = 2;
    localparam int rx_wait   = 4;   // Edges allowed for a late rx_valid

    logic                  baud_clk;
    logic                  rst_n;
    logic [data_bits-1:0]  tx_data;
    logic                  start_tx;
    logic                  tx;
    logic                  tx_busy;
    logic                  rx;
    logic                  rx_valid;
    rx_result_t            rx_result;
    logic                  use_raw;   // Select raw driver onto rx
    logic                  raw_bit;   // Raw frame bit

    // Test table with the reset check in slot 0
    int                    n_tests;
    int                    mode_a     [max_tests+1];
    logic                  chain_a    [max_tests+1];  // Strobe on previous stop bit
    logic [frame_bits-1:0] payload_a  [max_tests+1];  // Byte or raw frame
    logic [data_bits-1:0]  exp_data_a [max_tests+1];
    logic                  exp_perr_a [max_tests+1];
    logic                  exp_ferr_a [max_tests+1];
    int                    test_errs  [max_tests+1];
    logic                  rx_done    [max_tests+1];  // Result seen or given up
    int                    pend_q[$];                 // Frames in flight with oldest first
    int                    errors;
    int                    next_report;
    logic                  loaded;

    assign rx = use_raw ? raw_bit : tx;  // Loopback unless a raw frame is driven

    uart_link_top dut0 (
        .baud_clk  (baud_clk),
        .rst_n     (rst_n),
        .tx_data   (tx_data),
        .start_tx  (start_tx),
        .tx        (tx),
        .tx_busy   (tx_busy),
        .rx        (rx),
        .rx_valid  (rx_valid),
        .rx_result (rx_result)
    );

    initial begin
        baud_clk = 1'b0;
        forever #5 baud_clk = ~baud_clk;  // One period per bit
    end

    task automatic check(input int idx, input string name,
                         input logic [15:0] got, input logic [15:0] exp);
        if (got !== exp) begin
            $display("Error: test %0d %s got 0x%h, expected 0x%h", idx, name, got, exp);
            errors++;
            test_errs[idx]++;
        end
    endtask

    task automatic report_problem(input int idx, input string msg);
        $display("Test %0d failed: %s", idx, msg);
        errors++;
        test_errs[idx]++;
    endtask

    // Expected line bits with bit 0 sent first
    function automatic logic [frame_bits-1:0] line_bits(input logic [data_bits-1:0] b);
        logic par;
        par = ($countones(b) % 2) != 0;  // Even count of ones over data and parity
        return {1'b1, par, b, 1'b0};
    endfunction

    function automatic string mode_name(input int idx);
        if (idx == 0) begin
            return "reset";
        end
        case (mode_a[idx])
            mode_loop: return "loop";
            mode_raw:  return "raw";
            default:   return "busy";
        endcase
    endfunction

    task automatic load_stimulus(output logic ok);
        int               fd;
        int               m, r, c, p, d, pe, fe;
        int               got;
        logic [8*160-1:0] line;
        ok      = 1'b0;
        n_tests = 0;
        fd      = $fopen("bench/uart_stimulus.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && n_tests < max_tests) begin
                line = '0;
                got  = 0;
                if ($fgets(line, fd) != 0) begin
                    got = $sscanf(line, "%h %h %h %h %h %h %h", m, r, c, p, d, pe, fe);
                end
                if (got == 7) begin  // Comment lines fail the scan
                    n_tests++;
                    if (r != 0) begin
                        d = int'($urandom() % 256);  // Random byte replaces the column
                        p = d;
                    end
                    mode_a[n_tests]     = m;
                    payload_a[n_tests]  = frame_bits'(p);
                    exp_data_a[n_tests] = data_bits'(d);
                    exp_perr_a[n_tests] = (pe != 0);
                    exp_ferr_a[n_tests] = (fe != 0);
                    // Chaining needs a transmit frame on both sides
                    chain_a[n_tests] = (c != 0) && (n_tests > 1) && (m != mode_raw)
                                       && (mode_a[n_tests-1] != mode_raw);
                end
            end
            $fclose(fd);
            ok = (n_tests > 0);
        end
    endtask

    // Strobe a byte, then follow the 11 line bits and the busy window
    task automatic send_frame(input int idx);
        logic [frame_bits-1:0] exp_line;
        logic                  chain_next;
        int                    b;
        exp_line   = line_bits(payload_a[idx][data_bits-1:0]);
        chain_next = (idx < n_tests) && chain_a[idx+1];
        if (!chain_a[idx]) begin
            repeat (1 + ($urandom() % 4)) @(posedge baud_clk);  // Idle gap
            start_tx <= 1'b1;
            tx_data  <= payload_a[idx][data_bits-1:0];
            pend_q.push_back(idx);
            @(negedge baud_clk);
            check(idx, "tx_busy", 16'(tx_busy), 16'h0);  // Strobe cycle is still idle
            check(idx, "tx", 16'(tx), 16'h1);
        end
        for (b = 0; b < frame_bits; b++) begin
            @(posedge baud_clk);
            start_tx <= 1'b0;
            if (mode_a[idx] == mode_busy && b == 4) begin
                start_tx <= 1'b1;  // Must be ignored mid frame
                tx_data  <= ~payload_a[idx][data_bits-1:0];
            end
            if (b == frame_bits - 1 && chain_next) begin
                start_tx <= 1'b1;  // Seen on the stop-bit edge
                tx_data  <= payload_a[idx+1][data_bits-1:0];
                pend_q.push_back(idx + 1);
            end
            @(negedge baud_clk);
            check(idx, "tx", 16'(tx), 16'(exp_line[b]));
            check(idx, "tx_busy", 16'(tx_busy), 16'h1);
        end
        if (!chain_next) begin
            @(negedge baud_clk);
            check(idx, "tx_busy", 16'(tx_busy), 16'h0);  // Window ends after 11
            check(idx, "tx", 16'(tx), 16'h1);
        end
    endtask

    // Raw frame goes straight onto rx at one bit per edge
    task automatic drive_raw(input int idx);
        int b;
        repeat (1 + ($urandom() % 4)) @(posedge baud_clk);
        pend_q.push_back(idx);
        use_raw <= 1'b1;
        for (b = 0; b < frame_bits; b++) begin
            raw_bit <= payload_a[idx][b];
            @(posedge baud_clk);
        end
        raw_bit <= 1'b1;
        use_raw <= 1'b0;
    endtask

    task automatic wait_rx();
        int w;
        int idx;
        w = 0;
        while (pend_q.size() != 0 && w < rx_wait) begin
            @(posedge baud_clk);
            w++;
        end
        while (pend_q.size() != 0) begin
            idx = pend_q.pop_front();
            report_problem(idx, "rx_valid never arrived");
            rx_done[idx] = 1'b1;
        end
    endtask

    task automatic print_result(input int idx);
        if (test_errs[idx] == 0) begin
            $display("Test %0d %s: pass", idx, mode_name(idx));
        end else begin
            $display("Test %0d %s: FAIL with %0d errors", idx, mode_name(idx), test_errs[idx]);
        end
    endtask

    // Lines come out in test order once a result is in
    task automatic report_finished();
        while (next_report <= n_tests && rx_done[next_report]) begin
            print_result(next_report);
            next_report++;
        end
    endtask

    initial begin : rx_monitor
        int idx;
        forever begin
            @(negedge baud_clk);
            if (rst_n && rx_valid) begin
                if (pend_q.size() == 0) begin
                    $display("Unexpected rx_valid with no frame in flight");
                    errors++;
                end else begin
                    idx = pend_q.pop_front();
                    check(idx, "rx_result.data", 16'(rx_result.data), 16'(exp_data_a[idx]));
                    check(idx, "rx_result.parity_err", 16'(rx_result.parity_err),
                          16'(exp_perr_a[idx]));
                    check(idx, "rx_result.framing_err", 16'(rx_result.framing_err),
                          16'(exp_ferr_a[idx]));
                    rx_done[idx] = 1'b1;
                end
            end
        end
    end

    initial begin : watchdog
        wait (loaded);
        repeat (n_tests * 40 + 16) @(posedge baud_clk);  // 40 per test plus reset
        $display("Timeout: tests did not finish within %0d cycles", n_tests * 40 + 16);
        $display("Done: errors found");
        $finish;
    end

    initial begin : main
        logic ok;
        int   i;
        int   failed;
        rst_n       = 1'b0;
        start_tx    = 1'b0;
        tx_data     = '0;
        use_raw     = 1'b0;
        raw_bit     = 1'b1;   // Line idles high
        errors      = 0;
        loaded      = 1'b0;
        next_report = 1;
        void'($urandom(89));
        for (i = 0; i <= max_tests; i++) begin
            test_errs[i] = 0;
            rx_done[i]   = 1'b0;
        end
        load_stimulus(ok);
        if (!ok) begin
            $display("Could not read any test from bench/uart_stimulus.txt");
            $display("Done: errors found");
            $finish;
        end else begin
            loaded = 1'b1;
            repeat (16) @(posedge baud_clk);
            rst_n <= 1'b1;
            @(negedge baud_clk);
            check(0, "tx", 16'(tx), 16'h1);
            check(0, "tx_busy", 16'(tx_busy), 16'h0);
            check(0, "rx_valid", 16'(rx_valid), 16'h0);
            rx_done[0] = 1'b1;
            print_result(0);
            for (i = 1; i <= n_tests; i++) begin
                if (mode_a[i] == mode_raw) begin
                    drive_raw(i);
                end else begin
                    send_frame(i);
                end
                if (!(i < n_tests && chain_a[i+1])) begin
                    wait_rx();  // Chained frames are picked up later
                end
                report_finished();
            end
            wait_rx();
            report_finished();
            failed = 0;
            for (i = 0; i <= n_tests; i++) begin
                if (test_errs[i] != 0) begin
                    failed++;
                end
            end
            $display("Tests run %0d, failed %0d, errors %0d", n_tests + 1, failed, errors);
            if (errors == 0) begin
                $display("Done: no errors");
            end else begin
                $display("Done: errors found");
            end
            $finish;
        end
    end

endmodule : uart_link_tb

//--- bench/uart_stimulus.txt
# Columns, all hex: mode rand chain payload exp_data exp_perr exp_ferr
# mode 0 loopback, 1 raw frame on rx, 2 strobe while busy; rand 1 picks the byte; chain 1 = no gap
0 0 0 0a5 a5 0 0
0 0 0 000 00 0 0
0 0 0 0ff ff 0 0
0 0 0 001 01 0 0
0 0 0 080 80 0 0
0 0 1 055 55 0 0
0 0 1 0aa aa 0 0
0 0 1 03c 3c 0 0
0 1 0 000 00 0 0
0 1 1 000 00 0 0
0 1 1 000 00 0 0
0 1 0 000 00 0 0
2 0 0 05a 5a 0 0
2 0 1 0c3 c3 0 0
2 1 0 000 00 0 0
1 0 0 54a a5 0 0
1 0 0 74a a5 1 0
1 0 0 400 00 0 0
1 0 0 600 00 1 0
1 0 0 000 00 0 1
1 0 0 602 01 0 0
1 0 0 402 01 1 0
1 0 0 202 01 0 1
1 0 0 5fe ff 0 0
1 0 0 1fe ff 0 1
1 0 0 3fe ff 1 1
1 0 0 72c 96 1 0
1 0 0 300 80 0 1
0 0 0 07e 7e 0 0
0 1 1 000 00 0 0

//--- src.f
common/uart_cfg_pkg.sv
common/uart_frame_pkg.sv
uart_tx/tx_ctrl_fsm.sv
uart_tx/tx_bit_counter.sv
uart_tx/tx_frame_shifter.sv
uart_rx/rx_frame_sampler.sv
design/uart_link_top.sv
bench/uart_link_tb.sv

//--- Makefile
# Verilator build and run of the UART link testbench

SRCS := $(shell grep -v '^+' src.f)

.PHONY: all run clean

all: run

# Rebuilt only when the file list or a source changes
obj_dir/Vuart_link_tb: src.f $(SRCS)
	verilator --binary --timing --top-module uart_link_tb -f src.f

run: obj_dir/Vuart_link_tb
	./obj_dir/Vuart_link_tb | tee sim.log
	@if grep -q "^Done: no errors$$" sim.log; then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
